/* hw/hisBuilder_cfg.svh */
`ifndef HISBUILDER_CFG_SVH
`define HISBUILDER_CFG_SVH

// rough timestamp code width from the TDC
`define NP 7

// bin index width, 16 bins per histogram
`define NB 4

// low code bits dropped for a coarse bin, 8 codes per bin
`define COARSE_SHIFT (`NP - `NB)

// strobes collected in each pass
`define ACQ_COUNT 16

// count width, must hold ACQ_COUNT so no bin can wrap
`define CNT_W 5

// accepted strobe counter width
`define SAMPLE_CNT_W 5

`endif

/* hw/hisBuilderPkg.sv */
`include "hisBuilder_cfg.svh"

package hisBuilderPkg;

    // raw code as delivered with wrEn
    typedef logic [`NP-1:0] roughCode_t;

    // index into the 16 bin histogram
    typedef logic [`NB-1:0] binIdx_t;

    // hits held in one bin
    typedef logic [`CNT_W-1:0] binCount_t;

    // pass sequencing, acquisition then scan for each histogram
    typedef enum logic [1:0] {
        COARSE_ACQ  = 2'd0,
        COARSE_SCAN = 2'd1,
        FINE_ACQ    = 2'd2,
        FINE_SCAN   = 2'd3
    } hisPhase_t;

    // accepted sample, mapper to memory
    typedef struct packed {
        logic    valid;
        binIdx_t bin;
    } binSample_t;

endpackage

/* hw/binMapper.sv */
`include "hisBuilder_cfg.svh"

module binMapper import hisBuilderPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wrEn,
    input  roughCode_t roughData,
    input  hisPhase_t  phase,
    input  roughCode_t windowBase,
    output binSample_t sampleIn
);

    binIdx_t    coarseBin;
    roughCode_t fineOffset;
    logic       inWindow;
    logic       acqPhase;
    logic       fineMode;
    logic       accept;
    binIdx_t    mappedBin;

    // coarse bin is just the upper code bits
    assign coarseBin = roughData[`NP-1:`COARSE_SHIFT];

    // offset into the fine window
    assign fineOffset = roughData - windowBase;

    // below base or 16 and more above it falls outside
    assign inWindow = (roughData >= windowBase) && (fineOffset[`NP-1:`NB] == '0);

    assign acqPhase = (phase == COARSE_ACQ) || (phase == FINE_ACQ);
    assign fineMode = (phase == FINE_ACQ);

    // strobes outside acquisition are ignored
    assign accept = wrEn && acqPhase && (!fineMode || inWindow);

    assign mappedBin = fineMode ? fineOffset[`NB-1:0] : coarseBin;

    // one cycle register stage toward the memory
    always_ff @(posedge clk) begin
        sampleIn.bin <= mappedBin;
        if (reset) begin
            sampleIn.valid <= 1'b0;
        end else begin
            sampleIn.valid <= accept;
        end
    end

endmodule

/* hw/histogramMemory.sv */
`include "hisBuilder_cfg.svh"

module histogramMemory import hisBuilderPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  binSample_t sampleIn,
    input  logic       scanEn,
    input  binIdx_t    scanAddr,
    output binCount_t  scanCount,
    output binIdx_t    scanBin,
    output logic       scanValid
);

    localparam int NumBins = 1 << `NB;

    binCount_t counts [NumBins];
    logic      sampleHit;
    binCount_t readCount;

    // last sample of a pass can land on the bin being read
    assign sampleHit = sampleIn.valid && (sampleIn.bin == scanAddr);

    // forward that increment into the scanned value
    assign readCount = counts[scanAddr] + binCount_t'(sampleHit);

    // count array
    // a scan read clears its bin, which wins over a forwarded hit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumBins; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumBins; i++) begin
                if (scanEn && (scanAddr == binIdx_t'(i))) begin
                    counts[i] <= '0;
                end else if (sampleIn.valid && (sampleIn.bin == binIdx_t'(i))) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    // scan data, one cycle behind the address
    always_ff @(posedge clk) begin
        scanCount <= readCount;
        scanBin   <= scanAddr;
    end

    // valid flag for the scan data
    always_ff @(posedge clk) begin
        if (reset) begin
            scanValid <= 1'b0;
        end else begin
            scanValid <= scanEn;
        end
    end

endmodule

/* hw/peakDetector.sv */
`include "hisBuilder_cfg.svh"

module peakDetector import hisBuilderPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  binCount_t scanCount,
    input  binIdx_t   scanBin,
    input  logic      scanValid,
    input  logic      scanLast,
    output binIdx_t   peakBin,
    output logic      peakReady
);

    binCount_t maxCount;
    binIdx_t   maxBin;
    logic      restart;
    logic      takeItem;

    // bin 0 opens every scan, drop what the last scan held
    assign restart = (scanBin == '0);

    // strictly greater only, ties keep the lower bin
    assign takeItem = restart || (scanCount > maxCount);

    always_ff @(posedge clk) begin
        if (reset) begin
            maxCount  <= '0;
            maxBin    <= '0;
            peakReady <= 1'b0;
        end else begin
            // final bin is settled on the same edge
            peakReady <= scanValid && scanLast;
            if (scanValid && takeItem) begin
                maxCount <= scanCount;
                maxBin   <= scanBin;
            end
        end
    end

    // held max is the result once peakReady is up
    assign peakBin = maxBin;

endmodule

/* hw/hisBuilderFsm.sv */
`include "hisBuilder_cfg.svh"

module hisBuilderFsm import hisBuilderPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wrEn,
    input  binIdx_t    peakBin,
    input  logic       peakReady,
    output hisPhase_t  phase,
    output logic       ready,
    output logic       hisNum,
    output roughCode_t windowBase,
    output logic       scanEn,
    output binIdx_t    scanAddr,
    output logic       scanLast,
    output logic       chDone,
    output logic       fhDone,
    output binIdx_t    peakCH,
    output binIdx_t    peakFH
);

    localparam logic [`SAMPLE_CNT_W-1:0] LastSample = `SAMPLE_CNT_W'(`ACQ_COUNT - 1);
    localparam binIdx_t LastAddr = '1;

    logic [`SAMPLE_CNT_W-1:0] sampleCnt;
    logic                     lastStrobe;

    // strobes only count in the acquisition phases
    assign ready  = (phase == COARSE_ACQ) || (phase == FINE_ACQ);
    assign hisNum = (phase == FINE_ACQ) || (phase == FINE_SCAN);

    // fine window starts at the first code of the coarse peak bin
    assign windowBase = {peakCH, {`COARSE_SHIFT{1'b0}}};

    assign lastStrobe = ready && wrEn && (sampleCnt == LastSample);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= COARSE_ACQ;
            sampleCnt <= '0;
            scanEn    <= 1'b0;
            scanAddr  <= '0;
            scanLast  <= 1'b0;
            chDone    <= 1'b0;
            fhDone    <= 1'b0;
            peakCH    <= '0;
            peakFH    <= '0;
        end else begin
            chDone <= 1'b0;
            fhDone <= 1'b0;

            // lines up with the memory output for the last bin
            scanLast <= scanEn && (scanAddr == LastAddr);

            // 16 consecutive scan addresses
            if (scanEn) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == LastAddr) begin
                    scanEn <= 1'b0;
                end
            end

            case (phase)
                COARSE_ACQ, FINE_ACQ: begin
                    if (lastStrobe) begin
                        sampleCnt <= '0;
                        scanEn    <= 1'b1;
                        scanAddr  <= '0;
                        phase     <= (phase == COARSE_ACQ) ? COARSE_SCAN : FINE_SCAN;
                    end else if (wrEn) begin
                        sampleCnt <= sampleCnt + 1'b1;
                    end
                end
                COARSE_SCAN: begin
                    // coarse peak also sets the fine window
                    if (peakReady) begin
                        peakCH <= peakBin;
                        chDone <= 1'b1;
                        phase  <= FINE_ACQ;
                    end
                end
                FINE_SCAN: begin
                    if (peakReady) begin
                        peakFH <= peakBin;
                        fhDone <= 1'b1;
                        phase  <= COARSE_ACQ;
                    end
                end
                default: phase <= COARSE_ACQ;
            endcase
        end
    end

endmodule

/* hw/hisBuilder.sv */
`include "hisBuilder_cfg.svh"

module hisBuilder import hisBuilderPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wrEn,
    input  roughCode_t roughData,
    output logic       ready,
    output logic       hisNum,
    output logic       chDone,
    output binIdx_t    peakCH,
    output logic       fhDone,
    output binIdx_t    peakFH
);

    binSample_t sampleIn;
    roughCode_t windowBase;
    hisPhase_t  phase;
    logic       scanEn;
    binIdx_t    scanAddr;
    logic       scanLast;
    binCount_t  scanCount;
    binIdx_t    scanBin;
    logic       scanValid;
    binIdx_t    peakBin;
    logic       peakReady;

    // producer, code to bin
    binMapper mapper (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .phase      (phase),
        .windowBase (windowBase),
        .sampleIn   (sampleIn)
    );

    // buffer, bin counts
    histogramMemory memory (
        .clk       (clk),
        .reset     (reset),
        .sampleIn  (sampleIn),
        .scanEn    (scanEn),
        .scanAddr  (scanAddr),
        .scanCount (scanCount),
        .scanBin   (scanBin),
        .scanValid (scanValid)
    );

    // consumer, max search
    peakDetector detector (
        .clk       (clk),
        .reset     (reset),
        .scanCount (scanCount),
        .scanBin   (scanBin),
        .scanValid (scanValid),
        .scanLast  (scanLast),
        .peakBin   (peakBin),
        .peakReady (peakReady)
    );

    hisBuilderFsm fsm (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .peakBin    (peakBin),
        .peakReady  (peakReady),
        .phase      (phase),
        .ready      (ready),
        .hisNum     (hisNum),
        .windowBase (windowBase),
        .scanEn     (scanEn),
        .scanAddr   (scanAddr),
        .scanLast   (scanLast),
        .chDone     (chDone),
        .fhDone     (fhDone),
        .peakCH     (peakCH),
        .peakFH     (peakFH)
    );

endmodule

/* testbench/hisBuilder_sva.sv */
`include "hisBuilder_cfg.svh"

module hisBuilder_sva import hisBuilderPkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      ready,
    input logic      hisNum,
    input logic      chDone,
    input logic      fhDone,
    input logic      scanEn,
    input logic      scanValid,
    input logic      peakReady
);
    timeunit 1ns;
    timeprecision 100ps;

    // coarse and fine results never land together
    noDoubleDone: assert property (@(posedge clk) disable iff (reset)
        !(chDone && fhDone))
        else $error("chDone and fhDone high on the same cycle");

    // no strobes taken while bins are read out or the peak is settling
    readyLowInScan: assert property (@(posedge clk) disable iff (reset)
        (scanEn || scanValid || peakReady) |-> !ready)
        else $error("ready high while a scan is running");

    // pass number flips together with a done pulse
    hisNumOnDone: assert property (@(posedge clk) disable iff (reset)
        (hisNum != $past(hisNum)) |-> (chDone || fhDone))
        else $error("hisNum changed without a done pulse");

    // done is a single cycle pulse
    donePulseWidth: assert property (@(posedge clk) disable iff (reset)
        (chDone || fhDone) |=> !(chDone || fhDone))
        else $error("done pulse longer than one cycle");

endmodule

// attach to every builder instance
bind hisBuilder hisBuilder_sva sva (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .hisNum    (hisNum),
    .chDone    (chDone),
    .fhDone    (fhDone),
    .scanEn    (scanEn),
    .scanValid (scanValid),
    .peakReady (peakReady)
);

/* testbench/hisBuilderTb.sv */
`include "hisBuilder_cfg.svh"

module hisBuilderTb import hisBuilderPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumTableRuns = 5;
    localparam int NumRandomRuns = 20;
    localparam int SelReady = 0;
    localparam int SelCh = 1;
    localparam int SelFh = 2;

    // one pass worth of codes
    typedef roughCode_t codeSet_t [`ACQ_COUNT];

    // expected result of a coarse plus fine run
    typedef struct packed {
        binIdx_t ch;
        binIdx_t fh;
    } peakPair_t;

    logic       clk;
    logic       reset;
    logic       wrEn;
    roughCode_t roughData;
    logic       ready;
    logic       hisNum;
    logic       chDone;
    binIdx_t    peakCH;
    logic       fhDone;
    binIdx_t    peakFH;

    int          errorCount;
    int          checkCount;
    logic        timedOut;
    logic [31:0] rngState;

    // run 0 cluster in bin 5, run 1 tie of bins 3 and 9 with bin 5 as leftover bait,
    // run 2 heavy top bin, run 3 one repeated code, run 4 tie at bins 0 and 1
    // run 4 ends on bin 0 while that bin is read first
    codeSet_t coarseTable [NumTableRuns] = '{
        '{41, 42, 44, 45, 46, 47, 3, 12, 20, 60, 70, 81, 90, 100, 110, 127},
        '{72, 73, 75, 79, 24, 25, 30, 31, 40, 43, 47, 0, 100, 101, 127, 64},
        '{127, 127, 127, 127, 127, 120, 121, 122, 123, 124, 125, 126, 1, 2, 3, 4},
        '{64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64, 64},
        '{8, 9, 10, 11, 12, 13, 14, 15, 0, 1, 2, 3, 4, 5, 6, 7}
    };

    // fine codes mix window hits with codes below the base and 16 or more above
    // run 2 has no hit at all
    codeSet_t fineTable [NumTableRuns] = '{
        '{43, 43, 43, 43, 50, 50, 50, 39, 38, 30, 56, 57, 60, 100, 40, 55},
        '{33, 33, 33, 27, 27, 24, 39, 23, 40, 0, 127, 26, 35, 36, 37, 38},
        '{0, 8, 16, 24, 32, 40, 48, 56, 64, 72, 80, 88, 96, 104, 112, 119},
        '{70, 70, 66, 66, 63, 80, 81, 90, 64, 65, 67, 68, 69, 71, 72, 73},
        '{5, 5, 5, 15, 16, 20, 127, 100, 1, 2, 3, 4, 6, 7, 8, 9}
    };

    peakPair_t expTable [NumTableRuns] = '{
        '{4'd5, 4'd3},
        '{4'd3, 4'd9},
        '{4'd15, 4'd0},
        '{4'd8, 4'd2},
        '{4'd0, 4'd5}
    };

    hisBuilder dut (
        .clk       (clk),
        .reset     (reset),
        .wrEn      (wrEn),
        .roughData (roughData),
        .ready     (ready),
        .hisNum    (hisNum),
        .chDone    (chDone),
        .peakCH    (peakCH),
        .fhDone    (fhDone),
        .peakFH    (peakFH)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // highest count, lowest bin on a tie, bin 0 when empty
    function automatic binIdx_t pickPeak(input int counts [16]);
        binIdx_t best;
        best = '0;
        for (int i = 1; i < 16; i++) begin
            if (counts[i] > counts[best]) begin
                best = binIdx_t'(i);
            end
        end
        return best;
    endfunction

    // reference coarse histogram, 8 codes per bin
    function automatic binIdx_t modelCoarse(input codeSet_t codes);
        int counts [16];
        for (int i = 0; i < 16; i++) begin
            counts[i] = 0;
        end
        for (int i = 0; i < `ACQ_COUNT; i++) begin
            counts[int'(codes[i]) / 8]++;
        end
        return pickPeak(counts);
    endfunction

    // reference fine histogram over 16 codes from the coarse peak base
    function automatic binIdx_t modelFine(input codeSet_t codes, input binIdx_t coarsePeak);
        int counts [16];
        int base;
        int offset;
        base = int'(coarsePeak) * 8;
        for (int i = 0; i < 16; i++) begin
            counts[i] = 0;
        end
        for (int i = 0; i < `ACQ_COUNT; i++) begin
            offset = int'(codes[i]) - base;
            if (offset >= 0 && offset < 16) begin
                counts[offset]++;
            end
        end
        return pickPeak(counts);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // sampled on the falling edge where outputs are settled
    task automatic waitHigh(input int sel, input int limit);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            case (sel)
                SelReady: seen = ready;
                SelCh:    seen = chDone;
                default:  seen = fhDone;
            endcase
        end
        if (!seen) begin
            timedOut = 1'b1;
            case (sel)
                SelReady: $display("Timeout: ready stayed low for %0d cycles", limit);
                SelCh:    $display("Timeout: no chDone pulse within %0d cycles", limit);
                default:  $display("Timeout: no fhDone pulse within %0d cycles", limit);
            endcase
        end
    endtask

    // inputs change 10 ns after the rising edge
    task automatic driveStrobe(input logic en, input roughCode_t code);
        @(posedge clk);
        #10;
        wrEn = en;
        roughData = code;
    endtask

    // 8 rising edges in reset, then the idle state is checked
    task automatic applyReset();
        reset = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        checkValue("ready", 32'(ready), 32'd1);
        checkValue("hisNum", 32'(hisNum), 32'd0);
        checkValue("chDone", 32'(chDone), 32'd0);
        checkValue("fhDone", 32'(fhDone), 32'd0);
        checkValue("peakCH", 32'(peakCH), 32'd0);
        checkValue("peakFH", 32'(peakFH), 32'd0);
    endtask

    // one pass, then strobes during the scan that must be ignored
    task automatic runPass(input codeSet_t codes, input logic fine, input binIdx_t expPeak);
        if (timedOut) return;
        waitHigh(SelReady, 40);
        if (timedOut) return;
        checkValue("hisNum", 32'(hisNum), 32'(fine));
        for (int i = 0; i < `ACQ_COUNT; i++) begin
            driveStrobe(1'b1, codes[i]);
        end
        for (int i = 0; i < 3; i++) begin
            driveStrobe(1'b1, 7'h55);
        end
        driveStrobe(1'b0, '0);
        waitHigh(fine ? SelFh : SelCh, 40);
        if (timedOut) return;
        if (fine) begin
            checkValue("peakFH", 32'(peakFH), 32'(expPeak));
        end else begin
            checkValue("peakCH", 32'(peakCH), 32'(expPeak));
        end
    endtask

    task automatic applyRun(input int runId, input string label, input codeSet_t coarse,
                            input codeSet_t fine, input peakPair_t exp);
        int errorsBefore;
        errorsBefore = errorCount;
        runPass(coarse, 1'b0, exp.ch);
        runPass(fine, 1'b1, exp.fh);
        if (timedOut) begin
            $display("run %0d %s: stopped by a timeout", runId, label);
        end else begin
            $display("run %0d %s: peakCH %h peakFH %h, %s", runId, label, peakCH, peakFH,
                     (errorCount == errorsBefore) ? "ok" : "mismatch");
        end
    endtask

    initial begin
        codeSet_t  coarse;
        codeSet_t  fine;
        peakPair_t exp;
        int        base;
        int        offset;
        clk = 1'b0;
        reset = 1'b1;
        wrEn = 1'b0;
        roughData = '0;
        errorCount = 0;
        checkCount = 0;
        timedOut = 1'b0;
        rngState = 32'h69fd;

        applyReset();
        for (int r = 0; r < NumTableRuns; r++) begin
            applyRun(r, "table", coarseTable[r], fineTable[r], expTable[r]);
        end

        // random codes, fine ones spread from 8 below to 23 above the base
        for (int r = 0; r < NumRandomRuns; r++) begin
            for (int i = 0; i < `ACQ_COUNT; i++) begin
                rngState = xorshift(rngState);
                coarse[i] = rngState[6:0];
            end
            exp.ch = modelCoarse(coarse);
            base = int'(exp.ch) * 8;
            for (int i = 0; i < `ACQ_COUNT; i++) begin
                rngState = xorshift(rngState);
                offset = int'(rngState[4:0]) - 8;
                fine[i] = roughCode_t'(base + offset);
            end
            exp.fh = modelFine(fine, exp.ch);
            applyRun(NumTableRuns + r, "random", coarse, fine, exp);
        end

        // half a coarse pass aimed at bin 12, then reset
        // leftover counts would pull the coarse peak away from bin 5
        if (!timedOut) begin
            for (int i = 0; i < 10; i++) begin
                driveStrobe(1'b1, 7'd100);
            end
            applyReset();
            applyRun(NumTableRuns + NumRandomRuns, "reset", coarseTable[0], fineTable[0],
                     expTable[0]);
        end

        $display("checks %0d, errors %0d, timeout %0d", checkCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* hisBuilder.f */
+incdir+hw
hw/hisBuilderPkg.sv
hw/binMapper.sv
hw/histogramMemory.sv
hw/peakDetector.sv
hw/hisBuilderFsm.sv
hw/hisBuilder.sv
testbench/hisBuilder_sva.sv
testbench/hisBuilderTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := hisBuilderTb
FILELIST := hisBuilder.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
